//--- rtl/wh_dma_macros.svh
// Size and field width defaults for the wormhole-to-DMA subsystem.
// WH_DMA_ADDR_WIDTH must not exceed WH_DMA_FLIT_WIDTH, and the header fields
// must fit in one flit. The derived widths below are not computed here, so
// keep them in step: BEAT_WIDTH = clog2(BURST_LEN), WORD_WIDTH = clog2(MEM_WORDS),
// and ID_WIDTH wide enough to index NUM_DMA endpoints.
`ifndef WH_DMA_MACROS_SVH
`define WH_DMA_MACROS_SVH

`define WH_DMA_FLIT_WIDTH 32
`define WH_DMA_ADDR_WIDTH 16
`define WH_DMA_BURST_LEN 4
`define WH_DMA_NUM_DMA 2

`define WH_DMA_CORD_WIDTH 6
`define WH_DMA_CID_WIDTH 2
`define WH_DMA_LEN_WIDTH 4

`define WH_DMA_MEM_WORDS 64

`define WH_DMA_ID_WIDTH 1
`define WH_DMA_BEAT_WIDTH 2
`define WH_DMA_WORD_WIDTH 6

`endif

//--- rtl/wh_dma_pkg.sv
// Shared types for the wormhole-to-DMA subsystem.
// The header flit layout is fixed by the field width macros; the unused
// field absorbs whatever is left of the flit.
`default_nettype none

`include "wh_dma_macros.svh"

package wh_dma_pkg;

  typedef logic [`WH_DMA_FLIT_WIDTH-1:0] flit_t;
  typedef logic [`WH_DMA_ADDR_WIDTH-1:0] dma_addr_t;
  typedef logic [`WH_DMA_ID_WIDTH-1:0] dma_id_t;

  // header flit, most significant field first
  typedef struct packed {
    logic [`WH_DMA_FLIT_WIDTH-2-2*`WH_DMA_CID_WIDTH-2*`WH_DMA_CORD_WIDTH
           -`WH_DMA_LEN_WIDTH:0] unused;
    logic                          write_not_read;
    logic [`WH_DMA_CID_WIDTH-1:0]  src_cid;
    logic [`WH_DMA_CORD_WIDTH-1:0] src_cord;
    logic [`WH_DMA_LEN_WIDTH-1:0]  len;
    logic [`WH_DMA_CID_WIDTH-1:0]  cid;
    logic [`WH_DMA_CORD_WIDTH-1:0] cord;
  } wh_header_s;

  typedef enum logic {
    DMA_READ  = 1'b0,
    DMA_WRITE = 1'b1
  } dma_op_e;

  typedef struct packed {
    dma_op_e   op;
    dma_addr_t addr;
  } dma_pkt_s;

  typedef enum logic [1:0] {SEND_RESET, SEND_READY, SEND_DMA_PKT, SEND_EVICT_DATA} send_state_e;
  typedef enum logic [1:0] {RECV_RESET, RECV_READY, RECV_HEADER, RECV_FILL_DATA} recv_state_e;
  typedef enum logic [1:0] {MEM_IDLE, MEM_WRITE, MEM_READ} mem_state_e;

endpackage

`default_nettype wire

//--- rtl/cache_dma_if.sv
// One endpoint's cache DMA channels.
// Packet and evict channels are valid/yumi (fanout to endpoint);
// the fill channel is valid/ready (endpoint to fanout).
`timescale 1ns/1ps
`default_nettype none

interface cache_dma_if ();

  // packet channel
  wh_dma_pkg::dma_pkt_s pkt;
  logic                 pkt_v;
  logic                 pkt_yumi;

  // evict data
  wh_dma_pkg::flit_t    data_out;
  logic                 data_out_v;
  logic                 data_out_yumi;

  // fill data
  wh_dma_pkg::flit_t    data_in;
  logic                 data_in_v;
  logic                 data_in_ready;

  modport fanout_mp (
    output pkt, pkt_v, data_out, data_out_v, data_in_ready,
    input  pkt_yumi, data_out_yumi, data_in, data_in_v
  );

  modport endpoint_mp (
    input  pkt, pkt_v, data_out, data_out_v, data_in_ready,
    output pkt_yumi, data_out_yumi, data_in, data_in_v
  );

endinterface

`default_nettype wire

//--- rtl/wh_to_dma_fanout.sv
// Wormhole link to an array of cache DMA endpoints.
// Inbound link is valid-then-ready, outbound is ready-and-valid.
// The endpoint is picked by wh_dma_id_i while the header is taken; no routing
// by coordinate is done. Fills go out one whole burst at a time.
// A large endpoint count lengthens the arbiter and mux paths.
`timescale 1ns/1ps
`default_nettype none

`include "wh_dma_macros.svh"

module wh_to_dma_fanout (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                link_v_i,
  input  wh_dma_pkg::flit_t   link_data_i,
  input  wh_dma_pkg::dma_id_t wh_dma_id_i,
  output logic                link_ready_o,
  output logic                link_v_o,
  output wh_dma_pkg::flit_t   link_data_o,
  input  logic                link_ready_i,
  cache_dma_if.fanout_mp      dma [`WH_DMA_NUM_DMA-1:0]
);

  localparam logic [`WH_DMA_BEAT_WIDTH-1:0] last_beat_lp =
    `WH_DMA_BEAT_WIDTH'(`WH_DMA_BURST_LEN - 1);

  logic [`WH_DMA_NUM_DMA-1:0] pkt_v;
  logic [`WH_DMA_NUM_DMA-1:0] pkt_yumi;
  logic [`WH_DMA_NUM_DMA-1:0] out_v;
  logic [`WH_DMA_NUM_DMA-1:0] out_yumi;
  logic [`WH_DMA_NUM_DMA-1:0] fill_v;
  logic [`WH_DMA_NUM_DMA-1:0] fill_ready;
  wh_dma_pkg::flit_t          fill_data [`WH_DMA_NUM_DMA];
  wh_dma_pkg::dma_pkt_s       pkt_out;
  wh_dma_pkg::flit_t          data_out;

  // packet and evict payload are broadcast, only the valids are steered
  for (genvar i = 0; i < `WH_DMA_NUM_DMA; i++) begin : g_port
    assign dma[i].pkt           = pkt_out;
    assign dma[i].pkt_v         = pkt_v[i];
    assign pkt_yumi[i]          = dma[i].pkt_yumi;
    assign dma[i].data_out      = data_out;
    assign dma[i].data_out_v    = out_v[i];
    assign out_yumi[i]          = dma[i].data_out_yumi;
    assign fill_data[i]         = dma[i].data_in;
    assign fill_v[i]            = dma[i].data_in_v;
    assign dma[i].data_in_ready = fill_ready[i];
  end

  // requester table, one entry per endpoint
  logic [`WH_DMA_CORD_WIDTH-1:0] src_cord_r [`WH_DMA_NUM_DMA];
  logic [`WH_DMA_CID_WIDTH-1:0]  src_cid_r [`WH_DMA_NUM_DMA];
  logic                          table_we;
  wh_dma_pkg::wh_header_s        header_in;

  assign header_in = wh_dma_pkg::wh_header_s'(link_data_i);

  always_ff @(posedge clk_i) begin
    if (table_we) begin
      src_cord_r[wh_dma_id_i] <= header_in.src_cord;
      src_cid_r[wh_dma_id_i]  <= header_in.src_cid;
    end
  end

  // send path: header, address flit, then evict flits for a write
  wh_dma_pkg::send_state_e           send_state_r, send_state_n;
  wh_dma_pkg::dma_op_e               op_r, op_n;
  wh_dma_pkg::dma_id_t               send_id_r, send_id_n;
  logic [`WH_DMA_BEAT_WIDTH-1:0]     send_beat_r, send_beat_n;

  always_comb begin
    send_state_n = send_state_r;
    op_n         = op_r;
    send_id_n    = send_id_r;
    send_beat_n  = send_beat_r;
    table_we     = 1'b0;
    link_ready_o = 1'b0;
    pkt_v        = '0;
    out_v        = '0;
    pkt_out.op   = op_r;
    pkt_out.addr = wh_dma_pkg::dma_addr_t'(link_data_i);
    data_out     = link_data_i;

    case (send_state_r)
      wh_dma_pkg::SEND_RESET: begin
        send_state_n = wh_dma_pkg::SEND_READY;
      end
      wh_dma_pkg::SEND_READY: begin
        if (link_v_i) begin
          link_ready_o = 1'b1;
          table_we     = 1'b1;
          op_n         = wh_dma_pkg::dma_op_e'(header_in.write_not_read);
          send_id_n    = wh_dma_id_i;
          send_state_n = wh_dma_pkg::SEND_DMA_PKT;
        end
      end
      wh_dma_pkg::SEND_DMA_PKT: begin
        pkt_v[send_id_r] = link_v_i;
        link_ready_o     = pkt_yumi[send_id_r];
        if (pkt_yumi[send_id_r]) begin
          send_state_n = (op_r == wh_dma_pkg::DMA_WRITE) ? wh_dma_pkg::SEND_EVICT_DATA
                                                          : wh_dma_pkg::SEND_READY;
        end
      end
      wh_dma_pkg::SEND_EVICT_DATA: begin
        out_v[send_id_r] = link_v_i;
        link_ready_o     = out_yumi[send_id_r];
        if (out_yumi[send_id_r]) begin
          if (send_beat_r == last_beat_lp) begin
            send_beat_n  = '0;
            send_state_n = wh_dma_pkg::SEND_READY;
          end else begin
            send_beat_n = send_beat_r + 1'b1;
          end
        end
      end
      default: send_state_n = wh_dma_pkg::SEND_RESET;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      send_state_r <= wh_dma_pkg::SEND_RESET;
      op_r         <= wh_dma_pkg::DMA_READ;
      send_id_r    <= '0;
      send_beat_r  <= '0;
    end else begin
      send_state_r <= send_state_n;
      op_r         <= op_n;
      send_id_r    <= send_id_n;
      send_beat_r  <= send_beat_n;
    end
  end

  // receive path; recv_id_r doubles as the round-robin pointer
  wh_dma_pkg::recv_state_e       recv_state_r, recv_state_n;
  wh_dma_pkg::dma_id_t           recv_id_r;
  wh_dma_pkg::dma_id_t           rr_id;
  logic                          rr_v;
  logic                          rr_take;
  logic [`WH_DMA_BEAT_WIDTH-1:0] recv_beat_r, recv_beat_n;
  wh_dma_pkg::wh_header_s        reply_hdr_r;

  // search starts one past the last granted endpoint
  always_comb begin
    int idx;
    rr_v  = 1'b0;
    rr_id = recv_id_r;
    for (int k = 1; k <= `WH_DMA_NUM_DMA; k++) begin
      idx = (int'(recv_id_r) + k) % `WH_DMA_NUM_DMA;
      if (!rr_v && fill_v[idx]) begin
        rr_v  = 1'b1;
        rr_id = wh_dma_pkg::dma_id_t'(idx);
      end
    end
  end

  always_comb begin
    recv_state_n = recv_state_r;
    recv_beat_n  = recv_beat_r;
    rr_take      = 1'b0;
    link_v_o     = 1'b0;
    link_data_o  = '0;
    fill_ready   = '0;

    case (recv_state_r)
      wh_dma_pkg::RECV_RESET: begin
        recv_state_n = wh_dma_pkg::RECV_READY;
      end
      wh_dma_pkg::RECV_READY: begin
        rr_take = rr_v;
        if (rr_v) begin
          recv_state_n = wh_dma_pkg::RECV_HEADER;
        end
      end
      wh_dma_pkg::RECV_HEADER: begin
        link_v_o    = 1'b1;
        link_data_o = reply_hdr_r;
        if (link_ready_i) begin
          recv_state_n = wh_dma_pkg::RECV_FILL_DATA;
        end
      end
      wh_dma_pkg::RECV_FILL_DATA: begin
        link_v_o              = fill_v[recv_id_r];
        link_data_o           = fill_data[recv_id_r];
        fill_ready[recv_id_r] = link_ready_i;
        if (link_ready_i && fill_v[recv_id_r]) begin
          if (recv_beat_r == last_beat_lp) begin
            recv_beat_n  = '0;
            recv_state_n = wh_dma_pkg::RECV_READY;
          end else begin
            recv_beat_n = recv_beat_r + 1'b1;
          end
        end
      end
      default: recv_state_n = wh_dma_pkg::RECV_RESET;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      recv_state_r <= wh_dma_pkg::RECV_RESET;
      recv_beat_r  <= '0;
      recv_id_r    <= wh_dma_pkg::dma_id_t'(`WH_DMA_NUM_DMA - 1);
    end else begin
      recv_state_r <= recv_state_n;
      recv_beat_r  <= recv_beat_n;
      if (rr_take) begin
        recv_id_r <= rr_id;
      end
    end
  end

  // reply header is built at grant so it holds still under back-pressure,
  // even if a new request overwrites the table entry meanwhile
  always_ff @(posedge clk_i) begin
    if (rr_take) begin
      reply_hdr_r.unused         <= '0;
      reply_hdr_r.write_not_read <= 1'b0;
      reply_hdr_r.src_cid        <= '0;
      reply_hdr_r.src_cord       <= '0;
      reply_hdr_r.len            <= `WH_DMA_LEN_WIDTH'(`WH_DMA_BURST_LEN);
      reply_hdr_r.cid            <= src_cid_r[rr_id];
      reply_hdr_r.cord           <= src_cord_r[rr_id];
    end
  end

endmodule

`default_nettype wire

//--- rtl/dma_mem_endpoint.sv
// Burst memory behind one cache DMA interface.
// Addresses are byte addresses, burst-aligned; the word index is addr / 4
// and wraps inside WH_DMA_MEM_WORDS. Only full-burst writes, no byte enables.
// Memory contents are undefined until written.
`timescale 1ns/1ps
`default_nettype none

`include "wh_dma_macros.svh"

module dma_mem_endpoint (
  input  logic             clk_i,
  input  logic             reset_i,
  cache_dma_if.endpoint_mp dma
);

  localparam logic [`WH_DMA_BEAT_WIDTH-1:0] last_beat_lp =
    `WH_DMA_BEAT_WIDTH'(`WH_DMA_BURST_LEN - 1);

  wh_dma_pkg::flit_t             mem [`WH_DMA_MEM_WORDS];
  wh_dma_pkg::mem_state_e        state_r;
  logic [`WH_DMA_BEAT_WIDTH-1:0] beat_r;
  logic [`WH_DMA_WORD_WIDTH-1:0] base_r;
  logic [`WH_DMA_WORD_WIDTH-1:0] word;
  logic                          last_beat;

  // packets are only taken while idle
  assign dma.pkt_yumi      = (state_r == wh_dma_pkg::MEM_IDLE) && dma.pkt_v;
  assign dma.data_out_yumi = (state_r == wh_dma_pkg::MEM_WRITE) && dma.data_out_v;
  assign dma.data_in_v     = (state_r == wh_dma_pkg::MEM_READ);

  assign word        = base_r + `WH_DMA_WORD_WIDTH'(beat_r);
  assign dma.data_in = mem[word];
  assign last_beat   = (beat_r == last_beat_lp);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= wh_dma_pkg::MEM_IDLE;
      beat_r  <= '0;
    end else begin
      case (state_r)
        wh_dma_pkg::MEM_IDLE: begin
          if (dma.pkt_yumi) begin
            state_r <= (dma.pkt.op == wh_dma_pkg::DMA_WRITE) ? wh_dma_pkg::MEM_WRITE
                                                              : wh_dma_pkg::MEM_READ;
          end
        end
        wh_dma_pkg::MEM_WRITE: begin
          if (dma.data_out_yumi) begin
            beat_r <= last_beat ? '0 : beat_r + 1'b1;
            if (last_beat) begin
              state_r <= wh_dma_pkg::MEM_IDLE;
            end
          end
        end
        wh_dma_pkg::MEM_READ: begin
          if (dma.data_in_ready) begin
            beat_r <= last_beat ? '0 : beat_r + 1'b1;
            if (last_beat) begin
              state_r <= wh_dma_pkg::MEM_IDLE;
            end
          end
        end
        default: state_r <= wh_dma_pkg::MEM_IDLE;
      endcase
    end
  end

  // base word capture and the array write port
  always_ff @(posedge clk_i) begin
    if (dma.pkt_yumi) begin
      base_r <= dma.pkt.addr[`WH_DMA_WORD_WIDTH+1:2];
    end
    if (dma.data_out_yumi) begin
      mem[word] <= dma.data_out;
    end
  end

endmodule

`default_nettype wire

//--- rtl/wh_dma_subsystem.sv
// Top level: one wormhole link fanned out to burst memory endpoints.
// num_dma_p must equal WH_DMA_NUM_DMA, which sizes the fanout's port array.
// Link inbound is valid-then-ready, outbound is ready-and-valid.
`timescale 1ns/1ps
`default_nettype none

`include "wh_dma_macros.svh"

module wh_dma_subsystem #(
  parameter int num_dma_p = `WH_DMA_NUM_DMA
) (
  input  logic                clk_i,
  input  logic                reset_i,
  // inbound link
  input  logic                link_v_i,
  input  wh_dma_pkg::flit_t   link_data_i,
  input  wh_dma_pkg::dma_id_t wh_dma_id_i,
  output logic                link_ready_o,
  // outbound link
  output logic                link_v_o,
  output wh_dma_pkg::flit_t   link_data_o,
  input  logic                link_ready_i
);

  cache_dma_if dma_if [num_dma_p-1:0] ();

  wh_to_dma_fanout fanout0 (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .link_v_i     (link_v_i),
    .link_data_i  (link_data_i),
    .wh_dma_id_i  (wh_dma_id_i),
    .link_ready_o (link_ready_o),
    .link_v_o     (link_v_o),
    .link_data_o  (link_data_o),
    .link_ready_i (link_ready_i),
    .dma          (dma_if)
  );

  for (genvar i = 0; i < num_dma_p; i++) begin : g_ep
    dma_mem_endpoint ep (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .dma     (dma_if[i])
    );
  end

endmodule

`default_nettype wire

//--- verification/wh_dma_checker.sv
// Handshake assertions for wh_dma_subsystem, bound into the top level.
// An endpoint's data_in_v is high exactly in its read-burst state, so the
// fill valids stand in for the endpoint states.
`timescale 1ns/1ps
`default_nettype none

`include "wh_dma_macros.svh"

module wh_dma_checker (
  input logic                       clk_i,
  input logic                       reset_i,
  // outbound link valid, data and the sink's ready
  input logic                       out_v_i,
  input wh_dma_pkg::flit_t          out_data_i,
  input logic                       out_ready_i,
  // inbound link ready
  input logic                       in_ready_i,
  input logic [`WH_DMA_NUM_DMA-1:0] pkt_v_i,
  input logic [`WH_DMA_NUM_DMA-1:0] pkt_yumi_i,
  input logic [`WH_DMA_NUM_DMA-1:0] fill_v_i
);

  reset_quiet_a: assert property (@(posedge clk_i) reset_i |-> !out_v_i && !in_ready_i)
    else $error("link valid or ready high during reset");

  out_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    out_v_i && !out_ready_i |=> out_v_i && $stable(out_data_i))
    else $error("outbound flit dropped or changed under back-pressure");

  pkt_onehot_a: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(pkt_v_i))
    else $error("more than one endpoint offered a packet");

  for (genvar i = 0; i < `WH_DMA_NUM_DMA; i++) begin : g_ep
    read_no_pkt_a: assert property (@(posedge clk_i) disable iff (reset_i)
      !(fill_v_i[i] && pkt_yumi_i[i]))
      else $error("endpoint took a packet during a read burst");
  end

endmodule

bind wh_dma_subsystem wh_dma_checker checker0 (
  .clk_i        (clk_i),
  .reset_i      (reset_i),
  .out_v_i      (link_v_o),
  .out_data_i   (link_data_o),
  .out_ready_i  (link_ready_i),
  .in_ready_i   (link_ready_o),
  .pkt_v_i      (fanout0.pkt_v),
  .pkt_yumi_i   (fanout0.pkt_yumi),
  .fill_v_i     (fanout0.fill_v)
);

`default_nettype wire

//--- verification/wh_dma_tb.sv
// Trace-driven testbench for wh_dma_subsystem.
// The trace path is relative to the project root, so run from there.
// Only one request is kept in flight per endpoint while its fill is pending,
// because a new header would overwrite that endpoint's requester entry.
// Reads must only touch words that an earlier trace line wrote.
`timescale 1ns/1ps
`default_nettype none

`include "wh_dma_macros.svh"

module wh_dma_tb;

  localparam int clk_period_lp = 100;
  localparam int bl_lp         = `WH_DMA_BURST_LEN;
  localparam int ncid_lp       = 1 << `WH_DMA_CID_WIDTH;
  localparam int max_lines_lp  = 64;

  logic                clk_i;
  logic                reset_i;
  logic                link_v_i;
  wh_dma_pkg::flit_t   link_data_i;
  wh_dma_pkg::dma_id_t wh_dma_id_i;
  logic                link_ready_o;
  logic                link_v_o;
  wh_dma_pkg::flit_t   link_data_o;
  logic                link_ready_i;

  wh_dma_subsystem dut0 (.*);

  // columns per line: op, endpoint, cord, cid, addr, four data words
  logic [31:0]            trace_mem [max_lines_lp][9];
  int                     trace_len;
  bit                     trace_loaded;
  int                     error_count;
  int                     reads_sent;
  int                     reads_done;
  integer                 seed = 65;

  // reference memory and the reads waiting for their fill, keyed by cid
  wh_dma_pkg::flit_t      model_mem [`WH_DMA_NUM_DMA][`WH_DMA_MEM_WORDS];
  bit                     model_ok [`WH_DMA_NUM_DMA][`WH_DMA_MEM_WORDS];
  bit                     pending [`WH_DMA_NUM_DMA];
  bit                     exp_valid [ncid_lp];
  wh_dma_pkg::wh_header_s exp_hdr [ncid_lp];
  wh_dma_pkg::flit_t      exp_words [ncid_lp][bl_lp];
  int                     exp_line [ncid_lp];
  wh_dma_pkg::dma_id_t    exp_ep [ncid_lp];

  // reply stream state
  bit                     rx_busy;
  bit                     rx_known;
  int                     rx_cid;
  int                     rx_beat;
  int                     rx_errors;

  initial begin
    clk_i = 1'b0;
    forever #(clk_period_lp / 2) clk_i = ~clk_i;
  end

  task automatic check_header(input string name, input wh_dma_pkg::wh_header_s expected,
                              input wh_dma_pkg::wh_header_s actual, output bit ok);
    ok = (actual === expected);
    if (!ok) begin
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_flit(input string name, input wh_dma_pkg::flit_t expected,
                            input wh_dma_pkg::flit_t actual, output bit ok);
    ok = (actual === expected);
    if (!ok) begin
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  function automatic wh_dma_pkg::wh_header_s request_header(
      input wh_dma_pkg::dma_op_e op, input logic [`WH_DMA_CORD_WIDTH-1:0] cord,
      input logic [`WH_DMA_CID_WIDTH-1:0] cid);
    wh_dma_pkg::wh_header_s h;
    h                = '0;
    h.write_not_read = (op == wh_dma_pkg::DMA_WRITE);
    h.src_cord       = cord;
    h.src_cid        = cid;
    h.len            = `WH_DMA_LEN_WIDTH'(`WH_DMA_BURST_LEN);
    return h;
  endfunction

  // a fill goes back to the requester named in the request header
  function automatic wh_dma_pkg::wh_header_s reply_header(
      input logic [`WH_DMA_CORD_WIDTH-1:0] cord, input logic [`WH_DMA_CID_WIDTH-1:0] cid);
    wh_dma_pkg::wh_header_s h;
    h      = '0;
    h.cord = cord;
    h.cid  = cid;
    h.len  = `WH_DMA_LEN_WIDTH'(`WH_DMA_BURST_LEN);
    return h;
  endfunction

  task automatic load_trace(output bit ok);
    int    fd;
    int    n;
    string line;
    ok        = 1'b1;
    trace_len = 0;
    fd        = $fopen("verification/wh_dma_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open verification/wh_dma_trace.txt");
      ok = 1'b0;
    end else begin
      while (!$feof(fd) && trace_len < max_lines_lp) begin
        line = "";
        n    = $fgets(line, fd);
        // 8'h23 is the comment marker
        if (n > 1 && line.getc(0) != 8'h23) begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                      trace_mem[trace_len][0], trace_mem[trace_len][1],
                      trace_mem[trace_len][2], trace_mem[trace_len][3],
                      trace_mem[trace_len][4], trace_mem[trace_len][5],
                      trace_mem[trace_len][6], trace_mem[trace_len][7],
                      trace_mem[trace_len][8]);
          if (n != 9) begin
            $display("malformed trace line: %s", line);
            ok = 1'b0;
          end else begin
            trace_len++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // valid-then-ready, each flit held until link_ready_o is seen
  task automatic send_flit(input wh_dma_pkg::flit_t flit, input wh_dma_pkg::dma_id_t id);
    bit taken;
    link_v_i    = 1'b1;
    link_data_i = flit;
    wh_dma_id_i = id;
    taken       = 1'b0;
    while (!taken) begin
      #(clk_period_lp / 4);
      taken = link_ready_o;
      @(negedge clk_i);
    end
  endtask

  task automatic run_request(input int n);
    wh_dma_pkg::dma_op_e           op;
    wh_dma_pkg::dma_id_t           ep;
    logic [`WH_DMA_CORD_WIDTH-1:0] cord;
    logic [`WH_DMA_CID_WIDTH-1:0]  cid;
    wh_dma_pkg::dma_addr_t         addr;
    int                            word;
    op   = wh_dma_pkg::dma_op_e'(trace_mem[n][0][0]);
    ep   = wh_dma_pkg::dma_id_t'(trace_mem[n][1]);
    cord = trace_mem[n][2][`WH_DMA_CORD_WIDTH-1:0];
    cid  = trace_mem[n][3][`WH_DMA_CID_WIDTH-1:0];
    addr = trace_mem[n][4][`WH_DMA_ADDR_WIDTH-1:0];
    while (pending[ep] || exp_valid[cid]) @(negedge clk_i);
    if (op == wh_dma_pkg::DMA_READ) begin
      pending[ep]    = 1'b1;
      exp_valid[cid] = 1'b1;
      exp_line[cid]  = n;
      exp_ep[cid]    = ep;
      exp_hdr[cid]   = reply_header(cord, cid);
      for (int b = 0; b < bl_lp; b++) begin
        word                = (int'(addr) / 4 + b) % `WH_DMA_MEM_WORDS;
        exp_words[cid][b]   = model_mem[ep][word];
        if (!model_ok[ep][word]) begin
          $display("req%0d reads word %0d of endpoint %0d before any write", n, word, ep);
          error_count++;
        end
      end
      reads_sent++;
    end
    send_flit(request_header(op, cord, cid), ep);
    send_flit(wh_dma_pkg::flit_t'(addr), ep);
    if (op == wh_dma_pkg::DMA_WRITE) begin
      for (int b = 0; b < bl_lp; b++) begin
        word = (int'(addr) / 4 + b) % `WH_DMA_MEM_WORDS;
        send_flit(trace_mem[n][5+b], ep);
        model_mem[ep][word] = trace_mem[n][5+b];
        model_ok[ep][word]  = 1'b1;
      end
      $display("req%0d write endpoint %0d addr %h: sent", n, ep, addr);
    end
    link_v_i = 1'b0;
  endtask

  task automatic absorb_reply_flit(input wh_dma_pkg::flit_t flit);
    wh_dma_pkg::wh_header_s hdr;
    bit                     ok;
    if (!rx_busy) begin
      hdr       = wh_dma_pkg::wh_header_s'(flit);
      rx_cid    = int'(hdr.cid);
      rx_known  = exp_valid[rx_cid];
      rx_beat   = 0;
      rx_errors = 0;
      rx_busy   = 1'b1;
      if (!rx_known) begin
        $display("reply header %h names cid %0d, which has no read outstanding", flit, rx_cid);
        error_count++;
      end else begin
        check_header($sformatf("req%0d header", exp_line[rx_cid]), exp_hdr[rx_cid], hdr, ok);
        rx_errors += int'(!ok);
      end
    end else begin
      if (rx_known) begin
        check_flit($sformatf("req%0d beat%0d", exp_line[rx_cid], rx_beat),
                   exp_words[rx_cid][rx_beat], flit, ok);
        rx_errors += int'(!ok);
      end
      rx_beat++;
      if (rx_beat == bl_lp) begin
        rx_busy = 1'b0;
        if (rx_known) begin
          error_count += rx_errors;
          reads_done++;
          exp_valid[rx_cid]       = 1'b0;
          pending[exp_ep[rx_cid]] = 1'b0;
          $display("req%0d read endpoint %0d: %s", exp_line[rx_cid], exp_ep[rx_cid],
                   (rx_errors == 0) ? "ok" : "FAILED");
        end
      end
    end
  endtask

  // sink with random back-pressure, about three cycles in four ready
  initial begin : receive_proc
    while (reset_i !== 1'b0) @(negedge clk_i);
    forever begin
      @(negedge clk_i);
      link_ready_i = (($random(seed) & 3) != 0);
      #(clk_period_lp / 4);
      if (link_v_o && link_ready_i) begin
        absorb_reply_flit(link_data_o);
      end
    end
  end

  initial begin : watchdog_proc
    int limit;
    while (!trace_loaded) @(posedge clk_i);
    limit = trace_len * (bl_lp + 2) * 8 + 10;
    repeat (limit) @(posedge clk_i);
    $display("watchdog expired after %0d cycles with %0d of %0d reads done",
             limit, reads_done, reads_sent);
    $display("Checks failed");
    $finish;
  end

  initial begin : main_proc
    bit ok;
    link_v_i     = 1'b0;
    link_data_i  = '0;
    wh_dma_id_i  = '0;
    link_ready_i = 1'b0;
    reset_i      = 1'b1;
    error_count  = 0;
    reads_sent   = 0;
    reads_done   = 0;
    rx_busy      = 1'b0;
    trace_loaded = 1'b0;
    load_trace(ok);
    trace_loaded = ok;
    if (!ok || trace_len == 0) begin
      $display("no usable stimulus in the trace file");
      $display("Checks failed");
      $finish;
    end else begin
      repeat (10) @(posedge clk_i);
      @(negedge clk_i);
      reset_i = 1'b0;
      for (int n = 0; n < trace_len; n++) begin
        run_request(n);
      end
      while (reads_done < reads_sent) @(negedge clk_i);
      // idle a little so stray or duplicated flits still show up
      repeat (2 * (bl_lp + 2)) @(negedge clk_i);
      $display("%0d requests, %0d reads checked, %0d errors",
               trace_len, reads_done, error_count);
      if (error_count == 0) begin
        $display("All checks passed");
      end else begin
        $display("Checks failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- verification/wh_dma_trace.txt
# op ep cord cid addr d0 d1 d2 d3, all hex; op 1 is a write, 0 a read
# data words are used by writes only; a read expects the last data written
1 0 05 1 0010 11110000 11110001 11110002 11110003
0 0 05 1 0010 00000000 00000000 00000000 00000000
1 0 0a 2 0040 aaaa0000 aaaa0001 aaaa0002 aaaa0003
1 1 0b 3 0040 bbbb0000 bbbb0001 bbbb0002 bbbb0003
0 0 12 0 0040 00000000 00000000 00000000 00000000
0 1 21 3 0040 00000000 00000000 00000000 00000000
1 1 3f 0 00f0 c0de0000 c0de0001 c0de0002 c0de0003
0 1 3f 2 00f0 00000000 00000000 00000000 00000000
1 0 07 1 0080 d00d0000 d00d0001 d00d0002 d00d0003
1 1 08 2 0080 e00e0000 e00e0001 e00e0002 e00e0003
0 0 07 1 0080 00000000 00000000 00000000 00000000
0 1 08 2 0080 00000000 00000000 00000000 00000000
1 0 01 0 0010 f00f0000 f00f0001 f00f0002 f00f0003
1 1 2a 1 00fc 5a5a0000 5a5a0001 5a5a0002 5a5a0003
0 0 01 3 0010 00000000 00000000 00000000 00000000
0 1 1c 0 00fc 00000000 00000000 00000000 00000000
0 0 2d 1 0040 00000000 00000000 00000000 00000000
0 1 33 2 0040 00000000 00000000 00000000 00000000

//--- wh_dma.f
+incdir+rtl
rtl/wh_dma_pkg.sv
rtl/cache_dma_if.sv
rtl/wh_to_dma_fanout.sv
rtl/dma_mem_endpoint.sv
rtl/wh_dma_subsystem.sv
verification/wh_dma_checker.sv
verification/wh_dma_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= wh_dma_tb
FILELIST  ?= wh_dma.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All checks passed

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard rtl/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
